/* Bender.yml */
package:
  name: mips16_pipe

sources:
  - common/isa_pkg.sv
  - common/pipe_pkg.sv
  - common/wb_bus_if.sv
  - decode/reg_file.sv
  - decode/decode_stage.sv
  - fetch/fetch_stage.sv
  - execute/execute_stage.sv
  - source/mem_wb_stage.sv
  - source/hazard_unit.sv
  - source/cpu_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/cpu_tb.sv

/* common/isa_pkg.sv */
package isa_pkg;

    localparam int WORD_W     = 16;
    localparam int REG_ADDR_W = 3;

    // register count of the general file
    localparam int NUM_REGS = 8;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [WORD_W-1:0]     addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [4:0]            opcode_t;
    typedef logic [1:0]            funct_t;

    // ************************************************************************
    // opcodes, bits 15:11
    // ************************************************************************

    localparam opcode_t OP_NOP   = 5'b00001;
    localparam opcode_t OP_B     = 5'b00010;
    localparam opcode_t OP_BEQZ  = 5'b00100;
    localparam opcode_t OP_ADDIU = 5'b01001;
    localparam opcode_t OP_LI    = 5'b01101;
    localparam opcode_t OP_LW    = 5'b10011;
    localparam opcode_t OP_SW    = 5'b11011;
    localparam opcode_t OP_RRR   = 5'b11100;

    // RRR function field, bits 1:0
    localparam funct_t FN_ADDU = 2'b01;
    localparam funct_t FN_SUBU = 2'b11;

    // encoded NOP, also the bubble in IF/ID
    localparam word_t NOP_INST = {OP_NOP, 11'b0};

endpackage

/* common/pipe_pkg.sv */
package pipe_pkg;

    typedef logic [1:0] alu_op_t;
    typedef logic       b_sel_t;
    typedef logic       wb_sel_t;
    typedef logic [1:0] branch_t;

    localparam alu_op_t ALU_ADD    = 2'd0;
    localparam alu_op_t ALU_SUB    = 2'd1;
    // result is operand b, used by LI
    localparam alu_op_t ALU_PASS_B = 2'd2;

    localparam b_sel_t B_SEL_REG = 1'b0;
    localparam b_sel_t B_SEL_IMM = 1'b1;

    localparam wb_sel_t WB_SEL_ALU = 1'b0;
    localparam wb_sel_t WB_SEL_MEM = 1'b1;

    localparam branch_t BR_NONE    = 2'd0;
    localparam branch_t BR_IF_ZERO = 2'd1;
    localparam branch_t BR_ALWAYS  = 2'd2;

endpackage

/* common/wb_bus_if.sv */
`timescale 1ns/1ps

// one register write still in flight down the pipe
interface wb_bus_if
    import isa_pkg::*;
();

    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;
    // data comes from memory, not the ALU
    logic      is_load;

    modport producer (output wr_en, output wr_addr, output wr_data, output is_load);
    modport consumer (input wr_en, input wr_addr, input wr_data, input is_load);

endinterface

/* decode/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk_50MHz,
    input  logic      rst,
    input  logic      flush,
    input  logic      stall,
    input  word_t     if_inst,
    input  addr_t     if_pc_next,
    output reg_addr_t rs_addr_a,
    output reg_addr_t rs_addr_b,
    input  word_t     rs_data_a,
    input  word_t     rs_data_b,
    output logic      uses_a,
    output logic      uses_b,
    output alu_op_t   id_ex_alu_op,
    output b_sel_t    id_ex_b_sel,
    output wb_sel_t   id_ex_wb_sel,
    output branch_t   id_ex_branch,
    output logic      id_ex_mem_we,
    output logic      id_ex_mem_re,
    output reg_addr_t id_ex_rd_addr,
    output logic      id_ex_rd_en,
    output reg_addr_t id_ex_rs_a,
    output reg_addr_t id_ex_rs_b,
    output word_t     id_ex_op_a,
    output word_t     id_ex_op_b,
    output word_t     id_ex_imm,
    output addr_t     id_ex_pc_next
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rz;
    alu_op_t   alu_op;
    b_sel_t    b_sel;
    wb_sel_t   wb_sel;
    branch_t   branch;
    logic      mem_we, mem_re, rd_en;
    reg_addr_t rd_addr;
    word_t     imm;

    assign opcode    = if_inst[15:11];
    assign rs_addr_a = if_inst[10:8];
    assign rs_addr_b = if_inst[7:5];
    assign rz        = if_inst[4:2];
    assign funct     = if_inst[1:0];

    always_comb begin
        alu_op  = ALU_ADD;
        b_sel   = B_SEL_IMM;
        wb_sel  = WB_SEL_ALU;
        branch  = BR_NONE;
        mem_we  = 1'b0;
        mem_re  = 1'b0;
        rd_en   = 1'b0;
        rd_addr = rs_addr_a;
        uses_a  = 1'b0;
        uses_b  = 1'b0;
        imm     = {{8{if_inst[7]}}, if_inst[7:0]};
        case (opcode)
            OP_ADDIU: begin
                rd_en  = 1'b1;
                uses_a = 1'b1;
            end
            OP_LI: begin
                alu_op = ALU_PASS_B;
                rd_en  = 1'b1;
                imm    = {8'b0, if_inst[7:0]};
            end
            OP_RRR: begin
                alu_op  = (funct == FN_SUBU) ? ALU_SUB : ALU_ADD;
                b_sel   = B_SEL_REG;
                rd_addr = rz;
                // other function codes fall back to NOP
                rd_en   = (funct == FN_ADDU) || (funct == FN_SUBU);
                uses_a  = 1'b1;
                uses_b  = 1'b1;
            end
            OP_LW: begin
                wb_sel  = WB_SEL_MEM;
                mem_re  = 1'b1;
                rd_en   = 1'b1;
                rd_addr = rs_addr_b;
                uses_a  = 1'b1;
                imm     = {{11{if_inst[4]}}, if_inst[4:0]};
            end
            OP_SW: begin
                mem_we = 1'b1;
                uses_a = 1'b1;
                // ry is the store data
                uses_b = 1'b1;
                imm    = {{11{if_inst[4]}}, if_inst[4:0]};
            end
            OP_BEQZ: begin
                branch = BR_IF_ZERO;
                uses_a = 1'b1;
            end
            OP_B: begin
                branch = BR_ALWAYS;
                imm    = {{5{if_inst[10]}}, if_inst[10:0]};
            end
            default: ;
        endcase
    end

    // ID/EX, bubble on stall or flush
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_ex_branch <= BR_NONE;
            id_ex_mem_we <= 1'b0;
            id_ex_mem_re <= 1'b0;
            id_ex_rd_en  <= 1'b0;
        end else if (stall || flush) begin
            id_ex_branch <= BR_NONE;
            id_ex_mem_we <= 1'b0;
            id_ex_mem_re <= 1'b0;
            id_ex_rd_en  <= 1'b0;
        end else begin
            id_ex_branch <= branch;
            id_ex_mem_we <= mem_we;
            id_ex_mem_re <= mem_re;
            id_ex_rd_en  <= rd_en;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        id_ex_alu_op  <= alu_op;
        id_ex_b_sel   <= b_sel;
        id_ex_wb_sel  <= wb_sel;
        id_ex_rd_addr <= rd_addr;
        id_ex_rs_a    <= rs_addr_a;
        id_ex_rs_b    <= rs_addr_b;
        id_ex_op_a    <= rs_data_a;
        id_ex_op_b    <= rs_data_b;
        id_ex_imm     <= imm;
        id_ex_pc_next <= if_pc_next;
    end

endmodule

/* decode/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import isa_pkg::*;
(
    input  logic       clk_50MHz,
    input  logic       rst,
    input  reg_addr_t  rd_addr_a,
    input  reg_addr_t  rd_addr_b,
    output word_t      rd_data_a,
    output word_t      rd_data_b,
    wb_bus_if.consumer wb
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wr_en) begin
            regs[wb.wr_addr] <= wb.wr_data;
        end
    end

    // write-through, the WB value is seen in the same cycle
    assign rd_data_a = (wb.wr_en && wb.wr_addr == rd_addr_a) ? wb.wr_data : regs[rd_addr_a];
    assign rd_data_b = (wb.wr_en && wb.wr_addr == rd_addr_b) ? wb.wr_data : regs[rd_addr_b];

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk_50MHz,
    input  logic       rst,
    input  alu_op_t    id_ex_alu_op,
    input  b_sel_t     id_ex_b_sel,
    input  wb_sel_t    id_ex_wb_sel,
    input  branch_t    id_ex_branch,
    input  logic       id_ex_mem_we,
    input  logic       id_ex_mem_re,
    input  reg_addr_t  id_ex_rd_addr,
    input  logic       id_ex_rd_en,
    input  reg_addr_t  id_ex_rs_a,
    input  reg_addr_t  id_ex_rs_b,
    input  word_t      id_ex_op_a,
    input  word_t      id_ex_op_b,
    input  word_t      id_ex_imm,
    input  addr_t      id_ex_pc_next,
    wb_bus_if.consumer mem_wb,
    wb_bus_if.producer ex_mem,
    output logic       branch_taken,
    output addr_t      branch_target,
    output addr_t      dmem_addr,
    output word_t      dmem_wdata,
    output logic       dmem_we,
    output logic       dmem_re
);

    word_t op_a, op_b, alu_b, alu_y;

    // ************************************************************************
    // forwarding, EX/MEM before MEM/WB before the register file
    // ************************************************************************

    function automatic word_t forward(input reg_addr_t src, input word_t reg_val);
        word_t val;
        val = reg_val;
        // a load in EX/MEM has no data yet, the stall covers that case
        if (ex_mem.wr_en && !ex_mem.is_load && ex_mem.wr_addr == src) begin
            val = ex_mem.wr_data;
        end else if (mem_wb.wr_en && mem_wb.wr_addr == src) begin
            val = mem_wb.wr_data;
        end
        return val;
    endfunction

    assign op_a  = forward(id_ex_rs_a, id_ex_op_a);
    assign op_b  = forward(id_ex_rs_b, id_ex_op_b);
    assign alu_b = (id_ex_b_sel == B_SEL_IMM) ? id_ex_imm : op_b;

    always_comb begin
        case (id_ex_alu_op)
            ALU_SUB:    alu_y = op_a - alu_b;
            ALU_PASS_B: alu_y = alu_b;
            default:    alu_y = op_a + alu_b;
        endcase
    end

    // branch resolution
    always_comb begin
        case (id_ex_branch)
            BR_IF_ZERO: branch_taken = (op_a == '0);
            BR_ALWAYS:  branch_taken = 1'b1;
            default:    branch_taken = 1'b0;
        endcase
    end

    assign branch_target = id_ex_pc_next + id_ex_imm;

    // ************************************************************************
    // EX/MEM
    // ************************************************************************

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_mem.wr_en   <= 1'b0;
            ex_mem.is_load <= 1'b0;
            dmem_we        <= 1'b0;
            dmem_re        <= 1'b0;
        end else begin
            ex_mem.wr_en   <= id_ex_rd_en;
            ex_mem.is_load <= id_ex_rd_en && (id_ex_wb_sel == WB_SEL_MEM);
            dmem_we        <= id_ex_mem_we;
            dmem_re        <= id_ex_mem_re;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        ex_mem.wr_addr <= id_ex_rd_addr;
        ex_mem.wr_data <= alu_y;
        dmem_wdata     <= op_b;
    end

    // memory address is the ALU result held in EX/MEM
    assign dmem_addr = ex_mem.wr_data;

endmodule

/* fetch/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage
    import isa_pkg::*;
#(
    parameter addr_t RESET_PC = '0
) (
    input  logic  clk_50MHz,
    input  logic  rst,
    input  logic  stall,
    input  logic  flush,
    input  logic  branch_taken,
    input  addr_t branch_target,
    output addr_t imem_addr,
    input  word_t imem_data,
    output word_t if_inst,
    output addr_t if_pc_next
);

    addr_t pc;
    addr_t pc_plus1;

    assign pc_plus1  = pc + addr_t'(1);
    assign imem_addr = pc;

    // a taken branch wins over a stall
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc <= RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc_plus1;
        end
    end

    // IF/ID
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            if_inst <= NOP_INST;
        end else if (flush) begin
            if_inst <= NOP_INST;
        end else if (!stall) begin
            if_inst <= imem_data;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!stall) begin
            if_pc_next <= pc_plus1;
        end
    end

endmodule

/* files.f */
+incdir+sim
common/isa_pkg.sv
common/pipe_pkg.sv
common/wb_bus_if.sv
decode/reg_file.sv
decode/decode_stage.sv
fetch/fetch_stage.sv
execute/execute_stage.sv
source/mem_wb_stage.sv
source/hazard_unit.sv
source/cpu_top.sv
sim/cpu_tb.sv

/* sim/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// program lengths in words, the last word is the B-to-self halt
localparam int ARITH_LEN    = 10;
localparam int LOAD_USE_LEN = 8;
localparam int BRANCH_LEN   = 14;
localparam int IMM_LEN      = 7;

// ****************************************************************************
// dependent arithmetic chain
// ****************************************************************************

task automatic arith_program();
    place_inst(0, li_inst(3'd1, 8'h05));
    // rx + sext(0xFD) is rx - 3
    place_inst(1, addiu_inst(3'd1, 8'hFD));
    place_inst(2, li_inst(3'd2, 8'h07));
    place_inst(3, rrr_inst(3'd1, 3'd2, 3'd3, FN_ADDU));
    place_inst(4, rrr_inst(3'd3, 3'd1, 3'd4, FN_SUBU));
    place_inst(5, li_inst(3'd0, 8'h40));
    place_inst(6, sw_inst(3'd0, 3'd4, 5'd0));
    place_inst(7, sw_inst(3'd0, 3'd3, 5'd1));
    place_inst(8, sw_inst(3'd0, 3'd1, 5'd2));
    place_inst(9, b_inst(11'h7FF));
    // r1 = 5 - 3, r3 = r1 + 7, r4 = r3 - r1
    expect_store(16'h0040, (16'd5 - 16'd3 + 16'd7) - (16'd5 - 16'd3));
    expect_store(16'h0041, 16'd5 - 16'd3 + 16'd7);
    expect_store(16'h0042, 16'd5 - 16'd3);
endtask

task automatic load_use_program();
    place_inst(0, li_inst(3'd1, 8'h20));
    place_inst(1, li_inst(3'd2, 8'h33));
    place_inst(2, li_inst(3'd4, 8'h11));
    place_inst(3, sw_inst(3'd1, 3'd2, 5'd0));
    place_inst(4, lw_inst(3'd1, 3'd3, 5'd0));
    // uses r3 straight after the load
    place_inst(5, rrr_inst(3'd3, 3'd4, 3'd5, FN_ADDU));
    place_inst(6, sw_inst(3'd1, 3'd5, 5'd1));
    place_inst(7, b_inst(11'h7FF));
    expect_store(16'h0020, 16'h0033);
    expect_store(16'h0021, 16'h0033 + 16'h0011);
    expect_load(16'h0020);
endtask

task automatic branch_program();
    place_inst(0, li_inst(3'd1, 8'h00));
    place_inst(1, li_inst(3'd2, 8'h03));
    place_inst(2, li_inst(3'd7, 8'h50));
    // taken, 3 + 1 + 2 lands on word 6
    place_inst(3, beqz_inst(3'd1, 8'h02));
    place_inst(4, sw_inst(3'd7, 3'd2, 5'd0));
    place_inst(5, sw_inst(3'd7, 3'd2, 5'd1));
    place_inst(6, sw_inst(3'd7, 3'd1, 5'd2));
    // r2 is nonzero, falls through
    place_inst(7, beqz_inst(3'd2, 8'h03));
    place_inst(8, sw_inst(3'd7, 3'd2, 5'd3));
    place_inst(9, b_inst(11'h002));
    place_inst(10, sw_inst(3'd7, 3'd2, 5'd4));
    place_inst(11, sw_inst(3'd7, 3'd2, 5'd5));
    place_inst(12, sw_inst(3'd7, 3'd7, 5'd6));
    place_inst(13, b_inst(11'h7FF));
    expect_store(16'h0052, 16'h0000);
    expect_store(16'h0053, 16'h0003);
    expect_store(16'h0056, 16'h0050);
endtask

task automatic imm_program();
    place_inst(0, li_inst(3'd1, 8'hFF));
    place_inst(1, li_inst(3'd6, 8'h60));
    place_inst(2, sw_inst(3'd6, 3'd1, 5'd0));
    place_inst(3, addiu_inst(3'd1, 8'hFF));
    place_inst(4, sw_inst(3'd6, 3'd1, 5'd1));
    // imm5 0x1E is minus 2
    place_inst(5, sw_inst(3'd6, 3'd1, 5'h1E));
    place_inst(6, b_inst(11'h7FF));
    expect_store(16'h0060, 16'h00FF);
    expect_store(16'h0061, 16'h00FF - 16'd1);
    expect_store(16'h0060 - 16'd2, 16'h00FF - 16'd1);
endtask

`endif

/* sim/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb
    import isa_pkg::*;
();

    localparam addr_t RESET_PC = 16'h0010;

    logic  clk_50MHz;
    logic  rst;
    addr_t imem_addr;
    word_t imem_data;
    addr_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;
    logic  dmem_we;
    logic  dmem_re;

    word_t imem [256];
    word_t dmem [256];
    addr_t log_addr [$];
    word_t log_data [$];
    addr_t exp_addr [$];
    word_t exp_data [$];
    addr_t load_log [$];
    addr_t exp_load [$];
    addr_t st_addr;
    word_t st_data;
    int    errors = 0;
    int    cycles = 0;

    // ************************************************************************
    // instruction encoding
    // ************************************************************************

    function automatic word_t li_inst(input reg_addr_t rx, input logic [7:0] imm);
        return {OP_LI, rx, imm};
    endfunction

    function automatic word_t addiu_inst(input reg_addr_t rx, input logic [7:0] imm);
        return {OP_ADDIU, rx, imm};
    endfunction

    function automatic word_t rrr_inst(input reg_addr_t rx, input reg_addr_t ry,
                                       input reg_addr_t rz, input funct_t fn);
        return {OP_RRR, rx, ry, rz, fn};
    endfunction

    function automatic word_t lw_inst(input reg_addr_t rx, input reg_addr_t ry,
                                      input logic [4:0] imm);
        return {OP_LW, rx, ry, imm};
    endfunction

    function automatic word_t sw_inst(input reg_addr_t rx, input reg_addr_t ry,
                                      input logic [4:0] imm);
        return {OP_SW, rx, ry, imm};
    endfunction

    function automatic word_t beqz_inst(input reg_addr_t rx, input logic [7:0] imm);
        return {OP_BEQZ, rx, imm};
    endfunction

    function automatic word_t b_inst(input logic [10:0] imm);
        return {OP_B, imm};
    endfunction

    // untouched data words, unique per address
    function automatic word_t fill_word(input addr_t a);
        return {a[7:0], a[15:8]} ^ 16'hC35A;
    endfunction

    task automatic place_inst(input int idx, input word_t inst);
        addr_t a;
        a = RESET_PC + addr_t'(idx);
        imem[a[7:0]] = inst;
    endtask

    task automatic expect_store(input addr_t a, input word_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic expect_load(input addr_t a);
        exp_load.push_back(a);
    endtask

    `include "tb_programs.svh"

    localparam int CYCLE_LIMIT = 40 * (ARITH_LEN + LOAD_USE_LEN + BRANCH_LEN + IMM_LEN);

    cpu_top #(.RESET_PC(RESET_PC)) dut_i (
        .clk_50MHz, .rst, .imem_addr, .imem_data,
        .dmem_addr, .dmem_wdata, .dmem_rdata, .dmem_we, .dmem_re
    );

    initial clk_50MHz = 1'b0;
    always #10 clk_50MHz = ~clk_50MHz;

    // both memories read combinationally
    assign imem_data  = (imem_addr < 16'd256) ? imem[imem_addr[7:0]] : NOP_INST;
    assign dmem_rdata = (dmem_addr < 16'd256) ? dmem[dmem_addr[7:0]] : fill_word(dmem_addr);

    always @(posedge clk_50MHz) begin
        if (rst && dmem_re) begin
            load_log.push_back(dmem_addr);
        end
        if (rst && dmem_we) begin
            st_addr = dmem_addr;
            st_data = dmem_wdata;
            log_addr.push_back(st_addr);
            log_data.push_back(st_data);
            #1;
            if (st_addr < 16'd256) begin
                dmem[st_addr[7:0]] = st_data;
            end
        end
    end

    always @(posedge clk_50MHz) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            errors++;
            $display("timeout after %0d cycles, halt loop never reached", cycles);
            $display("errors: %0d", errors);
            $display("sim failed");
            $finish;
        end
    end

    // ************************************************************************
    // checks
    // ************************************************************************

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Fail %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic compare_stores(input string test);
        int n;
        n = (log_addr.size() < exp_addr.size()) ? log_addr.size() : exp_addr.size();
        if (log_addr.size() != exp_addr.size()) begin
            errors++;
            $display("%s test logged %0d stores where %0d were expected",
                     test, log_addr.size(), exp_addr.size());
        end
        for (int i = 0; i < n; i++) begin
            check_addr("dmem_addr", exp_addr[i], log_addr[i]);
            check_word("dmem_wdata", exp_data[i], log_data[i]);
        end
    endtask

    // one dmem_re cycle per load, at the load address
    task automatic compare_loads(input string test);
        int n;
        n = (load_log.size() < exp_load.size()) ? load_log.size() : exp_load.size();
        if (load_log.size() != exp_load.size()) begin
            errors++;
            $display("%s test logged %0d loads where %0d were expected",
                     test, load_log.size(), exp_load.size());
        end
        for (int i = 0; i < n; i++) begin
            check_addr("dmem_addr", exp_load[i], load_log[i]);
        end
    endtask

    // ************************************************************************
    // reset and run control
    // ************************************************************************

    task automatic hold_reset();
        @(posedge clk_50MHz);
        #1;
        rst = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = NOP_INST;
            dmem[i] = fill_word(addr_t'(i));
        end
        log_addr.delete();
        log_data.delete();
        exp_addr.delete();
        exp_data.delete();
        load_log.delete();
        exp_load.delete();
    endtask

    task automatic release_reset();
        repeat (8) begin
            @(negedge clk_50MHz);
            check_addr("imem_addr", RESET_PC, imem_addr);
            check_flag("dmem_we", 1'b0, dmem_we);
        end
        @(posedge clk_50MHz);
        #1;
        rst = 1'b1;
        // first cycle out of reset
        @(negedge clk_50MHz);
        check_addr("imem_addr", RESET_PC, imem_addr);
        check_flag("dmem_we", 1'b0, dmem_we);
    endtask

    // halt fetched, left on the wrong path, then fetched again
    task automatic wait_for_halt(input int len);
        addr_t halt_pc;
        halt_pc = RESET_PC + addr_t'(len - 1);
        while (imem_addr != halt_pc) @(negedge clk_50MHz);
        while (imem_addr == halt_pc) @(negedge clk_50MHz);
        while (imem_addr != halt_pc) @(negedge clk_50MHz);
    endtask

    task automatic arith_chain_test();
        hold_reset();
        arith_program();
        release_reset();
        wait_for_halt(ARITH_LEN);
        compare_stores("arith");
        compare_loads("arith");
    endtask

    task automatic load_use_test();
        hold_reset();
        load_use_program();
        release_reset();
        wait_for_halt(LOAD_USE_LEN);
        compare_stores("load-use");
        compare_loads("load-use");
    endtask

    task automatic branch_test();
        hold_reset();
        branch_program();
        release_reset();
        wait_for_halt(BRANCH_LEN);
        compare_stores("branch");
        compare_loads("branch");
    endtask

    task automatic immediate_test();
        hold_reset();
        imm_program();
        release_reset();
        wait_for_halt(IMM_LEN);
        compare_stores("immediate");
        compare_loads("immediate");
    endtask

    initial begin
        rst = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = NOP_INST;
            dmem[i] = fill_word(addr_t'(i));
        end
        arith_chain_test();
        load_use_test();
        branch_test();
        immediate_test();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter addr_t RESET_PC = '0
) (
    input  logic  clk_50MHz,
    input  logic  rst,
    output addr_t imem_addr,
    input  word_t imem_data,
    output addr_t dmem_addr,
    output word_t dmem_wdata,
    input  word_t dmem_rdata,
    output logic  dmem_we,
    output logic  dmem_re
);

    logic      stall, flush, branch_taken;
    addr_t     branch_target;
    word_t     if_inst;
    addr_t     if_pc_next;
    reg_addr_t rs_addr_a, rs_addr_b;
    word_t     rs_data_a, rs_data_b;
    logic      uses_a, uses_b;

    // ID/EX contents
    alu_op_t   id_ex_alu_op;
    b_sel_t    id_ex_b_sel;
    wb_sel_t   id_ex_wb_sel;
    branch_t   id_ex_branch;
    logic      id_ex_mem_we, id_ex_mem_re, id_ex_rd_en;
    reg_addr_t id_ex_rd_addr, id_ex_rs_a, id_ex_rs_b;
    word_t     id_ex_op_a, id_ex_op_b, id_ex_imm;
    addr_t     id_ex_pc_next;

    wb_bus_if ex_mem_wb ();
    wb_bus_if mem_wb_wb ();

    // ************************************************************************
    // stages
    // ************************************************************************

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_i (
        .clk_50MHz, .rst, .stall, .flush, .branch_taken, .branch_target,
        .imem_addr, .imem_data, .if_inst, .if_pc_next
    );

    decode_stage decode_i (
        .clk_50MHz, .rst, .flush, .stall, .if_inst, .if_pc_next,
        .rs_addr_a, .rs_addr_b, .rs_data_a, .rs_data_b, .uses_a, .uses_b,
        .id_ex_alu_op, .id_ex_b_sel, .id_ex_wb_sel, .id_ex_branch,
        .id_ex_mem_we, .id_ex_mem_re, .id_ex_rd_addr, .id_ex_rd_en,
        .id_ex_rs_a, .id_ex_rs_b, .id_ex_op_a, .id_ex_op_b, .id_ex_imm,
        .id_ex_pc_next
    );

    reg_file reg_file_i (
        .clk_50MHz, .rst,
        .rd_addr_a (rs_addr_a),
        .rd_addr_b (rs_addr_b),
        .rd_data_a (rs_data_a),
        .rd_data_b (rs_data_b),
        .wb        (mem_wb_wb.consumer)
    );

    execute_stage execute_i (
        .clk_50MHz, .rst,
        .id_ex_alu_op, .id_ex_b_sel, .id_ex_wb_sel, .id_ex_branch,
        .id_ex_mem_we, .id_ex_mem_re, .id_ex_rd_addr, .id_ex_rd_en,
        .id_ex_rs_a, .id_ex_rs_b, .id_ex_op_a, .id_ex_op_b, .id_ex_imm,
        .id_ex_pc_next,
        .mem_wb (mem_wb_wb.consumer),
        .ex_mem (ex_mem_wb.producer),
        .branch_taken, .branch_target, .dmem_addr, .dmem_wdata, .dmem_we, .dmem_re
    );

    mem_wb_stage mem_wb_i (
        .clk_50MHz, .rst,
        .ex_mem (ex_mem_wb.consumer),
        .dmem_rdata,
        .mem_wb (mem_wb_wb.producer)
    );

    hazard_unit hazard_i (
        .id_rs_a    (rs_addr_a),
        .id_rs_b    (rs_addr_b),
        .uses_a, .uses_b,
        .ex_rd_addr (id_ex_rd_addr),
        .ex_rd_en   (id_ex_rd_en),
        .ex_is_load (id_ex_mem_re),
        .branch_taken, .stall, .flush
    );

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit
    import isa_pkg::*;
(
    input  reg_addr_t id_rs_a,
    input  reg_addr_t id_rs_b,
    input  logic      uses_a,
    input  logic      uses_b,
    input  reg_addr_t ex_rd_addr,
    input  logic      ex_rd_en,
    input  logic      ex_is_load,
    input  logic      branch_taken,
    output logic      stall,
    output logic      flush
);

    logic hit_a, hit_b;

    // ID reads what the load in EX has not fetched yet
    assign hit_a = uses_a && (id_rs_a == ex_rd_addr);
    assign hit_b = uses_b && (id_rs_b == ex_rd_addr);
    assign stall = ex_rd_en && ex_is_load && (hit_a || hit_b);

    // squash IF and ID behind a taken branch
    assign flush = branch_taken;

endmodule

/* source/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage
    import isa_pkg::*;
(
    input  logic              clk_50MHz,
    input  logic              rst,
    wb_bus_if.consumer        ex_mem,
    input  word_t             dmem_rdata,
    wb_bus_if.producer        mem_wb
);

    word_t wb_value;

    // load data is taken straight off the data port
    assign wb_value = ex_mem.is_load ? dmem_rdata : ex_mem.wr_data;

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            mem_wb.wr_en   <= 1'b0;
            mem_wb.is_load <= 1'b0;
        end else begin
            mem_wb.wr_en   <= ex_mem.wr_en;
            mem_wb.is_load <= ex_mem.is_load;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        mem_wb.wr_addr <= ex_mem.wr_addr;
        mem_wb.wr_data <= wb_value;
    end

endmodule
